// ==== src/spy_pkg.sv ====
// Spy bus definitions
package spy_pkg;

   localparam int spy_data_w = 16;
   localparam int spy_addr_w = 3;

   typedef enum logic [spy_addr_w-1:0] {
      reg_scratch1    = 3'd0,
      reg_mode        = 3'd1,
      reg_clk         = 3'd2,
      reg_opc         = 3'd3,
      reg_status      = 3'd4,
      reg_pc          = 3'd5,
      reg_scratch2    = 3'd6,
      reg_set_promdis = 3'd7
   } spy_reg_e;

   localparam int mode_promdisable = 5;
   localparam int mode_trapenb     = 4;
   localparam int mode_stathenb    = 3;
   localparam int mode_errstop     = 2;

   localparam int clk_ldstat = 4;
   localparam int clk_idebug = 3;
   localparam int clk_nop11  = 2;
   localparam int clk_step   = 1;
   localparam int clk_run    = 0;

   localparam int opc_opcinh   = 2;
   localparam int opc_opcclk   = 1;
   localparam int opc_lpc_hold = 0;

   localparam int stat_machrun      = 0;
   localparam int stat_srun         = 1;
   localparam int stat_sstep        = 2;
   localparam int stat_ssdone       = 3;
   localparam int stat_stathalt     = 4;
   localparam int stat_promdisabled = 5;

endpackage

// ==== src/machine_pkg.sv ====
// Machine cycle definitions
package machine_pkg;

   localparam int pc_w = 16;

   localparam logic [15:0] scratch_reset = 16'h1234;
   localparam logic [pc_w-1:0] pc_reset = '0;

   typedef enum logic [1:0] {
      cyc_fetch   = 2'd0,
      cyc_execute = 2'd1,
      cyc_write   = 2'd2
   } cycle_state_e;

endpackage

// ==== src/spy_load_if.sv ====
// Spy register load strobes
`timescale 1ns/1ns

interface spy_load_if;

   logic ldmode;
   logic ldclk;
   logic ldopc;
   logic ldscratch;
   logic set_promdisable;
   logic [spy_pkg::spy_data_w-1:0] wdata;

   modport decode
   (
      output ldmode, ldclk, ldopc, ldscratch, set_promdisable, wdata
   );

   modport control
   (
      input ldmode, ldclk, ldopc, ldscratch, set_promdisable, wdata
   );

   modport monitor
   (
      input ldmode, ldclk, ldopc, ldscratch, set_promdisable, wdata
   );

endinterface

// ==== src/spy_decode.sv ====
// Spy write decoder
`timescale 1ns/1ns

module spy_decode
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           spy_wr,
   input  spy_pkg::spy_reg_e              spy_addr,
   input  logic [spy_pkg::spy_data_w-1:0] spy_wdata,
   spy_load_if.decode                     load
);

   always_comb
   begin
      load.ldmode          = 1'b0;
      load.ldclk           = 1'b0;
      load.ldopc           = 1'b0;
      load.ldscratch       = 1'b0;
      load.set_promdisable = 1'b0;
      if (spy_wr)
      begin
         case (spy_addr)
            spy_pkg::reg_scratch1,
            spy_pkg::reg_scratch2:    load.ldscratch = 1'b1; // two aliases, one register.
            spy_pkg::reg_mode:        load.ldmode = 1'b1;
            spy_pkg::reg_clk:         load.ldclk = 1'b1;
            spy_pkg::reg_opc:         load.ldopc = 1'b1;
            spy_pkg::reg_set_promdis: load.set_promdisable = 1'b1;
            default:                  ; // status and pc are read only.
         endcase
      end
   end

   assign load.wdata = spy_wdata;

   // a single write never loads two registers
   a_one_strobe: assert property (@(posedge clk) disable iff (reset)
      $onehot0({load.ldmode, load.ldclk, load.ldopc, load.ldscratch,
                load.set_promdisable}));

endmodule

// ==== src/overlord_control.sv ====
// Overlord run control
`timescale 1ns/1ns

module overlord_control
(
   input  logic                           clk,
   input  logic                           reset,
   spy_load_if.control                    load,
   input  logic                           boot,
   input  logic                           errhalt,
   input  logic                           waiting,
   input  logic                           statstop,
   input  logic                           state_fetch,
   output logic [spy_pkg::spy_data_w-1:0] scratch,
   output logic [spy_pkg::spy_data_w-1:0] mode_bits,
   output logic [spy_pkg::spy_data_w-1:0] clk_bits,
   output logic [spy_pkg::spy_data_w-1:0] opc_bits,
   output logic [spy_pkg::spy_data_w-1:0] status_bits,
   output logic                           run,
   output logic                           machrun,
   output logic                           stathalt,
   output logic                           promdisabled
);

   logic promdisable, trapenb, stathenb, errstop;
   logic ldstat, idebug, nop11, step;
   logic opcinh, opcclk, lpc_hold;
   logic srun, sstep, ssdone;
   logic step_active;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         promdisable <= 1'b0;
         trapenb     <= 1'b0;
         stathenb    <= 1'b0;
         errstop     <= 1'b0;
      end
      else if (load.ldmode)
      begin
         promdisable <= load.wdata[spy_pkg::mode_promdisable];
         trapenb     <= load.wdata[spy_pkg::mode_trapenb];
         stathenb    <= load.wdata[spy_pkg::mode_stathenb];
         errstop     <= load.wdata[spy_pkg::mode_errstop];
      end
      else if (load.set_promdisable)
         promdisable <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         scratch <= machine_pkg::scratch_reset;
      else if (load.ldscratch)
         scratch <= load.wdata;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         opcinh   <= 1'b0;
         opcclk   <= 1'b0;
         lpc_hold <= 1'b0;
         ldstat   <= 1'b0;
         idebug   <= 1'b0;
         nop11    <= 1'b0;
         step     <= 1'b0;
         run      <= 1'b0;
      end
      else
      begin
         if (load.ldopc)
         begin
            opcinh   <= load.wdata[spy_pkg::opc_opcinh];
            opcclk   <= load.wdata[spy_pkg::opc_opcclk];
            lpc_hold <= load.wdata[spy_pkg::opc_lpc_hold];
         end
         if (load.ldclk)
         begin
            ldstat <= load.wdata[spy_pkg::clk_ldstat];
            idebug <= load.wdata[spy_pkg::clk_idebug];
            nop11  <= load.wdata[spy_pkg::clk_nop11];
            step   <= load.wdata[spy_pkg::clk_step];
         end
         if (boot)
            run <= 1'b1; // boot wins over a clock write.
         else if (load.ldclk)
            run <= load.wdata[spy_pkg::clk_run];
      end
   end

   // a step stops at the first fetch after the machine has moved
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         srun         <= 1'b0;
         sstep        <= 1'b0;
         ssdone       <= 1'b0;
         step_active  <= 1'b0;
         promdisabled <= 1'b0;
      end
      else
      begin
         srun         <= run;
         sstep        <= step;
         step_active  <= sstep & ~ssdone;
         promdisabled <= promdisable;
         if (!sstep && step)
            ssdone <= 1'b0; // new step request.
         else if (state_fetch && step_active)
            ssdone <= sstep;
      end
   end

   assign stathalt = statstop & stathenb;
   assign machrun  = (sstep & ~ssdone) | (srun & ~errhalt & ~waiting & ~stathalt);

   always_comb
   begin
      mode_bits   = '0;
      clk_bits    = '0;
      opc_bits    = '0;
      status_bits = '0;
      mode_bits[spy_pkg::mode_promdisable]    = promdisable;
      mode_bits[spy_pkg::mode_trapenb]        = trapenb;
      mode_bits[spy_pkg::mode_stathenb]       = stathenb;
      mode_bits[spy_pkg::mode_errstop]        = errstop;
      clk_bits[spy_pkg::clk_ldstat]           = ldstat;
      clk_bits[spy_pkg::clk_idebug]           = idebug;
      clk_bits[spy_pkg::clk_nop11]            = nop11;
      clk_bits[spy_pkg::clk_step]             = step;
      clk_bits[spy_pkg::clk_run]              = run;
      opc_bits[spy_pkg::opc_opcinh]           = opcinh;
      opc_bits[spy_pkg::opc_opcclk]           = opcclk;
      opc_bits[spy_pkg::opc_lpc_hold]         = lpc_hold;
      status_bits[spy_pkg::stat_machrun]      = machrun;
      status_bits[spy_pkg::stat_srun]         = srun;
      status_bits[spy_pkg::stat_sstep]        = sstep;
      status_bits[spy_pkg::stat_ssdone]       = ssdone;
      status_bits[spy_pkg::stat_stathalt]     = stathalt;
      status_bits[spy_pkg::stat_promdisabled] = promdisabled;
   end

   a_errhalt_stops: assert property (@(posedge clk) disable iff (reset)
      (errhalt && !sstep) |-> !machrun);

endmodule

// ==== src/cycle_sequencer.sv ====
// Machine cycle sequencer
`timescale 1ns/1ns

module cycle_sequencer
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           machrun,
   output logic                           state_fetch,
   output logic [machine_pkg::pc_w-1:0]   pc,
   output machine_pkg::cycle_state_e      cycle_state
);

   machine_pkg::cycle_state_e next_state;

   always_comb
   begin
      case (cycle_state)
         machine_pkg::cyc_fetch:   next_state = machine_pkg::cyc_execute;
         machine_pkg::cyc_execute: next_state = machine_pkg::cyc_write;
         machine_pkg::cyc_write:   next_state = machine_pkg::cyc_fetch;
         default:                  next_state = machine_pkg::cyc_fetch;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         cycle_state <= machine_pkg::cyc_fetch;
         pc          <= machine_pkg::pc_reset;
      end
      else if (machrun)
      begin
         cycle_state <= next_state;
         if (cycle_state == machine_pkg::cyc_write)
            pc <= pc + 1'b1; // one instruction done.
      end
   end

   assign state_fetch = machrun && (cycle_state == machine_pkg::cyc_fetch);

   a_pc_on_write: assert property (@(posedge clk) disable iff (reset)
      !(machrun && cycle_state == machine_pkg::cyc_write) |=> $stable(pc));

endmodule

// ==== src/spy_readback.sv ====
// Spy read multiplexer
`timescale 1ns/1ns

module spy_readback
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           spy_rd,
   input  spy_pkg::spy_reg_e              spy_addr,
   input  logic [spy_pkg::spy_data_w-1:0] scratch,
   input  logic [spy_pkg::spy_data_w-1:0] mode_bits,
   input  logic [spy_pkg::spy_data_w-1:0] clk_bits,
   input  logic [spy_pkg::spy_data_w-1:0] opc_bits,
   input  logic [spy_pkg::spy_data_w-1:0] status_bits,
   input  logic [machine_pkg::pc_w-1:0]   pc,
   output logic [spy_pkg::spy_data_w-1:0] spy_rdata,
   output logic                           spy_rd_valid
);

   always_ff @(posedge clk)
   begin
      if (reset)
         spy_rd_valid <= 1'b0;
      else
         spy_rd_valid <= spy_rd;
   end

   always_ff @(posedge clk)
   begin
      if (spy_rd)
      begin
         case (spy_addr)
            spy_pkg::reg_scratch1: spy_rdata <= scratch;
            spy_pkg::reg_mode:     spy_rdata <= mode_bits;
            spy_pkg::reg_clk:      spy_rdata <= clk_bits;
            spy_pkg::reg_opc:      spy_rdata <= opc_bits;
            spy_pkg::reg_status:   spy_rdata <= status_bits;
            spy_pkg::reg_pc:       spy_rdata <= pc;
            default:               spy_rdata <= '0; // write only.
         endcase
      end
   end

endmodule

// ==== src/cadr_overlord.sv ====
// Overlord top level
`timescale 1ns/1ns

module cadr_overlord
(
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           spy_wr,
   input  logic                           spy_rd,
   input  logic [spy_pkg::spy_addr_w-1:0] spy_addr,
   input  logic [spy_pkg::spy_data_w-1:0] spy_wdata,
   input  logic                           boot,
   input  logic                           errhalt,
   input  logic                           waiting,
   input  logic                           statstop,
   output logic [spy_pkg::spy_data_w-1:0] spy_rdata,
   output logic                           spy_rd_valid,
   output logic                           run,
   output logic                           machrun,
   output logic                           stathalt,
   output logic                           promdisabled,
   output logic [machine_pkg::pc_w-1:0]   pc,
   output logic                           state_fetch
);

   logic [spy_pkg::spy_data_w-1:0] scratch;
   logic [spy_pkg::spy_data_w-1:0] mode_bits;
   logic [spy_pkg::spy_data_w-1:0] clk_bits;
   logic [spy_pkg::spy_data_w-1:0] opc_bits;
   logic [spy_pkg::spy_data_w-1:0] status_bits;

   spy_load_if load ();

   spy_decode u_decode
   (
      .clk       (clk),
      .reset     (reset),
      .spy_wr    (spy_wr),
      .spy_addr  (spy_pkg::spy_reg_e'(spy_addr)),
      .spy_wdata (spy_wdata),
      .load      (load)
   );

   overlord_control u_control
   (
      .clk          (clk),
      .reset        (reset),
      .load         (load),
      .boot         (boot),
      .errhalt      (errhalt),
      .waiting      (waiting),
      .statstop     (statstop),
      .state_fetch  (state_fetch),
      .scratch      (scratch),
      .mode_bits    (mode_bits),
      .clk_bits     (clk_bits),
      .opc_bits     (opc_bits),
      .status_bits  (status_bits),
      .run          (run),
      .machrun      (machrun),
      .stathalt     (stathalt),
      .promdisabled (promdisabled)
   );

   cycle_sequencer u_sequencer
   (
      .clk         (clk),
      .reset       (reset),
      .machrun     (machrun),
      .state_fetch (state_fetch),
      .pc          (pc),
      .cycle_state ()
   );

   spy_readback u_readback
   (
      .clk          (clk),
      .reset        (reset),
      .spy_rd       (spy_rd),
      .spy_addr     (spy_pkg::spy_reg_e'(spy_addr)),
      .scratch      (scratch),
      .mode_bits    (mode_bits),
      .clk_bits     (clk_bits),
      .opc_bits     (opc_bits),
      .status_bits  (status_bits),
      .pc           (pc),
      .spy_rdata    (spy_rdata),
      .spy_rd_valid (spy_rd_valid)
   );

endmodule

// ==== testbench/overlord_checker.sv ====
// Spy read and pc checker
`timescale 1ns/1ns

module overlord_checker
(
   input  logic        clk,
   input  logic        reset,
   input  logic        spy_rd,
   input  logic        spy_rd_valid,
   input  logic [15:0] spy_rdata,
   input  logic [15:0] exp_word,
   input  logic [15:0] exp_mask,
   input  logic        machrun,
   input  logic        stathalt,
   input  logic [15:0] pc,
   input  logic        run,
   input  logic        promdisabled,
   input  logic        state_fetch,
   input  logic        exp_run,
   input  logic        exp_promdisable,
   input  logic        level_check,
   input  logic        exp_machrun,
   input  logic        exp_stathalt,
   output int          error_count,
   output int          check_count
);

   int          errors = 0;
   int          checks = 0;
   int          phase = 0;
   logic        pending = 1'b0;
   logic [15:0] pend_word;
   logic [15:0] pend_mask;
   logic [15:0] model_pc = 16'd0;
   logic        prev_promdisable = 1'b0;

   assign error_count = errors;
   assign check_count = checks;

   task automatic value_error(input string msg);
      $display("CHECK FAILED at %0t: %s", $time, msg);
      errors = errors + 1;
   endtask

   always @(posedge clk)
   begin
      if (reset)
      begin
         pending          = 1'b0;
         phase            = 0;
         model_pc         = 16'd0;
         prev_promdisable = 1'b0;
      end
      else
      begin
         if (spy_rd_valid !== pending)
         begin
            $display("spy_rd_valid did not match the outstanding reads at %0t", $time);
            errors = errors + 1;
         end
         else if (pending)
         begin
            checks = checks + 1;
            if ((spy_rdata & pend_mask) !== (pend_word & pend_mask))
               value_error($sformatf("spy read %h, expected %h under mask %h",
                                     spy_rdata, pend_word, pend_mask));
         end
         pending   = spy_rd; // answered after the next edge.
         pend_word = exp_word;
         pend_mask = exp_mask;
         checks    = checks + 1;
         if (pc !== model_pc)
         begin
            value_error($sformatf("pc is %h, expected %h", pc, model_pc));
            model_pc = pc; // follow the DUT after a miss.
         end
         if (run !== exp_run)
            value_error($sformatf("run is %b, expected %b", run, exp_run));
         if (promdisabled !== prev_promdisable)
            value_error($sformatf("promdisabled is %b, expected %b",
                                  promdisabled, prev_promdisable));
         prev_promdisable = exp_promdisable; // status copy lags a cycle.
         if (state_fetch !== (machrun === 1'b1 && phase == 0))
            value_error($sformatf("state_fetch is %b with machrun %b in phase %0d",
                                  state_fetch, machrun, phase));
         if (machrun === 1'b1)
         begin
            phase = (phase == 2) ? 0 : phase + 1;
            if (phase == 0)
               model_pc = model_pc + 16'd1; // leaving the write state.
         end
         if (level_check && (machrun !== exp_machrun || stathalt !== exp_stathalt))
            value_error($sformatf("machrun %b stathalt %b, expected %b %b",
                                  machrun, stathalt, exp_machrun, exp_stathalt));
      end
   end

endmodule

// ==== testbench/cadr_overlord_tb.sv ====
// Overlord testbench
`timescale 1ns/1ns

module cadr_overlord_tb;

   localparam int clk_period  = 100;
   localparam int n_random    = 12;
   localparam int test_cycles = 8 * n_random + 200; // rough length of all tests.
   localparam int watchdog_ns = 3 * test_cycles * clk_period;

   logic        clk, reset, spy_wr, spy_rd, boot, errhalt, waiting, statstop;
   logic [2:0]  spy_addr;
   logic [15:0] spy_wdata, spy_rdata, pc;
   logic        spy_rd_valid, run, machrun, stathalt, promdisabled, state_fetch;
   logic [15:0] exp_word, exp_mask, data;
   logic        level_check, exp_machrun, exp_stathalt;
   logic        exp_run, exp_promdisable;
   logic [15:0] model [0:7];
   logic [15:0] lfsr = 16'd19;
   int          error_count;
   int          check_count;
   int          stall_errors = 0;

   assign exp_run         = model[2][0]; // run bit of the clock register.
   assign exp_promdisable = model[1][5]; // promdisable bit of the mode register.

   cadr_overlord UUT (.*);

   overlord_checker u_checker (.*);

   initial
   begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   initial
   begin
      #(watchdog_ns);
      $display("watchdog expired after %0d ns before the tests finished", watchdog_ns);
      $display("RESULT: FAIL");
      $finish;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
   endfunction

   // expected value of one register after a spy write
   function automatic logic [15:0] register_after_write(input int target,
      input spy_pkg::spy_reg_e addr, input logic [15:0] wdata, input logic [15:0] old);
      case (target)
         0: return (addr == spy_pkg::reg_scratch1 || addr == spy_pkg::reg_scratch2) ?
                   wdata : old;
         1: return (addr == spy_pkg::reg_mode) ? (wdata & 16'h003c) :
                   (addr == spy_pkg::reg_set_promdis) ? (old | 16'h0020) : old;
         2: return (addr == spy_pkg::reg_clk) ? (wdata & 16'h001f) : old;
         3: return (addr == spy_pkg::reg_opc) ? (wdata & 16'h0007) : old;
         default: return old; // status, pc and write only addresses.
      endcase
   endfunction

   task automatic random_word(input int nbits, output logic [15:0] word);
      word = 16'd0;
      repeat (nbits)
      begin
         lfsr = lfsr_next(lfsr);
         word = {word[14:0], lfsr[0]};
      end
   endtask

   task automatic spy_write(input spy_pkg::spy_reg_e addr, input logic [15:0] wdata);
      int r;
      spy_wr    = 1'b1;
      spy_addr  = addr;
      spy_wdata = wdata;
      @(negedge clk);
      spy_wr = 1'b0;
      for (r = 0; r < 8; r = r + 1)
         model[r[2:0]] = register_after_write(r, addr, wdata, model[r[2:0]]);
   endtask

   task automatic spy_read(input spy_pkg::spy_reg_e addr, input logic [15:0] word,
                           input logic [15:0] mask);
      spy_rd   = 1'b1;
      spy_addr = addr;
      exp_word = word;
      exp_mask = mask;
      @(negedge clk);
      spy_rd = 1'b0;
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      model = '{default: 16'h0000};
      model[0] = 16'h1234;
   endtask

   task automatic expect_levels(input logic enable, input logic run_exp, input logic halt_exp);
      level_check  = enable;
      exp_machrun  = run_exp;
      exp_stathalt = halt_exp;
   endtask

   task automatic wait_step_done();
      int n;
      n = 0;
      while (machrun !== 1'b1 && n < 8)
      begin
         @(negedge clk);
         n = n + 1;
      end
      while (machrun !== 1'b0 && n < 24)
      begin
         @(negedge clk);
         n = n + 1;
      end
      if (machrun !== 1'b0)
      begin
         $display("single step did not stop the machine by %0t", $time);
         stall_errors = stall_errors + 1;
      end
   endtask

   initial
   begin
      int i;
      int k;
      reset     = 1'b1;
      spy_wr    = 1'b0;
      spy_rd    = 1'b0;
      spy_addr  = 3'd0;
      spy_wdata = 16'h0000;
      boot      = 1'b0;
      errhalt   = 1'b0;
      waiting   = 1'b0;
      statstop  = 1'b0;
      exp_word  = 16'h0000;
      exp_mask  = 16'h0000;
      expect_levels(1'b0, 1'b0, 1'b0);
      apply_reset();
      for (i = 0; i < 8; i = i + 1)
         spy_read(spy_pkg::spy_reg_e'(i[2:0]), model[i[2:0]], 16'hffff);
      for (i = 0; i < n_random; i = i + 1)
      begin
         random_word(1, data);
         k = data[0];
         random_word(16, data);
         spy_write((k == 1) ? spy_pkg::reg_scratch2 : spy_pkg::reg_scratch1, data);
         spy_read(spy_pkg::reg_scratch1, model[0], 16'hffff);
      end
      for (i = 0; i < n_random; i = i + 1)
      begin
         for (k = 1; k < 4; k = k + 1) // mode, clock and opcode.
         begin
            random_word(16, data);
            spy_write(spy_pkg::spy_reg_e'(k[2:0]), data);
            spy_read(spy_pkg::spy_reg_e'(k[2:0]), model[k[2:0]], 16'hffff);
         end
      end
      spy_write(spy_pkg::reg_mode, 16'h0000);
      random_word(16, data);
      spy_write(spy_pkg::reg_set_promdis, data);
      spy_read(spy_pkg::reg_status, 16'h0000, 16'h0020); // promdisabled lags.
      spy_read(spy_pkg::reg_status, 16'h0020, 16'h0020);
      spy_read(spy_pkg::reg_mode, model[spy_pkg::reg_mode], 16'hffff);
      @(negedge clk); // the mode read returns before reset.

      apply_reset();
      boot = 1'b1;
      @(negedge clk);
      boot = 1'b0;
      model[spy_pkg::reg_clk] = model[spy_pkg::reg_clk] | 16'h0001; // boot sets run.
      @(negedge clk);
      expect_levels(1'b1, 1'b1, 1'b0);
      repeat (12) @(negedge clk);
      spy_read(spy_pkg::reg_clk, model[spy_pkg::reg_clk], 16'hffff);
      spy_read(spy_pkg::reg_status, 16'h0003, 16'h0013);

      spy_write(spy_pkg::reg_mode, 16'h0008); // stathenb.
      statstop = 1'b1;
      expect_levels(1'b1, 1'b0, 1'b1);
      repeat (6) @(negedge clk);
      spy_read(spy_pkg::reg_status, 16'h0012, 16'h0013);
      statstop = 1'b0;
      expect_levels(1'b1, 1'b1, 1'b0);
      spy_write(spy_pkg::reg_mode, 16'h0000);
      statstop = 1'b1;
      repeat (6) @(negedge clk);
      statstop = 1'b0;
      errhalt  = 1'b1;
      expect_levels(1'b1, 1'b0, 1'b0);
      repeat (6) @(negedge clk);
      errhalt = 1'b0;
      waiting = 1'b1;
      repeat (6) @(negedge clk);
      waiting = 1'b0;
      expect_levels(1'b1, 1'b1, 1'b0);
      repeat (6) @(negedge clk);
      expect_levels(1'b0, 1'b0, 1'b0);

      apply_reset();
      for (k = 1; k <= 3; k = k + 1)
      begin
         spy_write(spy_pkg::reg_clk, 16'h0000);
         spy_write(spy_pkg::reg_clk, 16'h0002);
         wait_step_done();
         spy_read(spy_pkg::reg_pc, 16'(k), 16'hffff);
         spy_read(spy_pkg::reg_status, 16'h000c, 16'h000f); // sstep and ssdone.
      end
      expect_levels(1'b1, 1'b0, 1'b0);
      spy_write(spy_pkg::reg_clk, 16'h0002);
      spy_write(spy_pkg::reg_clk, 16'h0002);
      repeat (4) @(negedge clk);
      spy_read(spy_pkg::reg_pc, 16'd3, 16'hffff);
      repeat (2) @(negedge clk);

      $display("checks: %0d, errors: %0d", check_count, error_count + stall_errors);
      if (error_count + stall_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== cadr_overlord.f ====
src/spy_pkg.sv
src/machine_pkg.sv
src/spy_load_if.sv
src/spy_decode.sv
src/overlord_control.sv
src/cycle_sequencer.sv
src/spy_readback.sv
src/cadr_overlord.sv
testbench/overlord_checker.sv
testbench/cadr_overlord_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module cadr_overlord_tb \
   -f cadr_overlord.f \
   -o cadr_overlord_sim \
   && ./obj_dir/cadr_overlord_sim | tee /dev/stderr | grep "RESULT: PASS" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
